// File: cache_pkg.sv
package cache_pkg;

    // address geometry, word addressed
    localparam int TAG_W      = 11;
    localparam int IDX_W      = 3;
    localparam int OFS_W      = 2;
    localparam int LINES      = 8;
    localparam int LINE_WORDS = 4;
    localparam int LADDR_W    = TAG_W + IDX_W;   // line address in backing memory

    typedef logic [15:0] word_t;

    typedef logic [LADDR_W-1:0] line_addr_t;

    typedef struct packed {
        logic [TAG_W-1:0] tag;
        logic [IDX_W-1:0] idx;
        logic [OFS_W-1:0] ofs;
    } addr_t;

    // memory moves the line as one word, caches pick single words out of it
    typedef union packed {
        logic [63:0]                    raw;
        word_t [0:LINE_WORDS-1]         words;   // word 0 in the top bits
    } mem_line_u;

    typedef enum logic {
        ICACHE = 1'b0,
        DCACHE = 1'b1
    } src_t;

    typedef struct packed {
        logic  valid;
        logic  write;
        addr_t addr;
        word_t wdata;
    } cpu_req_t;

    typedef struct packed {
        logic  valid;
        word_t rdata;
    } cpu_rsp_t;

    typedef struct packed {
        logic       valid;
        logic       write;
        src_t       src;
        line_addr_t line_addr;
        mem_line_u  wdata;
    } mem_req_t;

    typedef struct packed {
        logic      valid;
        src_t      src;
        mem_line_u rdata;
    } mem_rsp_t;

    // content of a word right after reset
    function automatic word_t init_word(input addr_t a);
        return word_t'(a) ^ 16'hA5A5;
    endfunction

endpackage

// File: cache_subsys_stim.txt
# columns: port (0 icache, 1 dcache), op (0 read, 1 write, 2 read with next line), address,
# write data, expected read data (writes expect their own word back), all hex
0 0 0010 0000 A5B5
0 0 0011 0000 A5B4
1 1 8004 1234 1234
1 0 8004 0000 1234
1 0 8005 0000 25A0
1 1 8008 BEEF BEEF
1 0 8028 0000 258D
1 0 8008 0000 BEEF
1 0 800A 0000 25AF
1 1 800B 5A5A 5A5A
1 0 802B 0000 258E
1 0 800B 0000 5A5A
1 0 8008 0000 BEEF
0 2 0040 0000 A5E5
1 0 8100 0000 24A5
0 0 0041 0000 A5E4
0 2 0123 0000 A486
1 1 81F0 C0DE C0DE
1 0 81F0 0000 C0DE
0 2 0050 0000 A5F5
1 0 8210 0000 27B5
1 0 81F0 0000 C0DE
0 0 0010 0000 A5B5
1 1 8004 7777 7777
0 2 0013 0000 A5B6
1 0 8024 0000 2581
1 0 8004 0000 7777
1 0 8006 0000 25A3

// File: cache_subsys_tb.sv
`timescale 1ns/1ps

module cache_subsys_tb import cache_pkg::*; ();

    localparam int         RAND_OPS   = 200;
    localparam int         CYC_PER_OP = 60;
    localparam logic [1:0] OP_READ    = 2'd0;
    localparam logic [1:0] OP_WRITE   = 2'd1;
    localparam logic [1:0] OP_PAIR    = 2'd2;   // read started with the next line

    typedef struct packed {
        logic        port;
        logic [1:0]  op;
        logic [15:0] addr;
        logic [15:0] wdata;
        logic [15:0] exp_data;
    } stim_t;

    logic             Clk;
    logic             arst_n;
    cpu_req_t         ireq;
    cpu_req_t         dreq;
    logic             iready;
    logic             dready;
    cpu_rsp_t         irsp;
    cpu_rsp_t         drsp;

    stim_t            stim_q [$];
    logic [15:0]      written [int];
    logic [TAG_W-1:0] shadow_tag [2][LINES];
    logic             shadow_valid [2][LINES];
    logic [15:0]      lfsr;
    logic             stim_loaded;
    int               n_checks;
    int               data_errors;
    int               latency_errors;
    int               other_errors;

    cache_subsys_top #(
        .MEM_QDEPTH  (2),
        .MEM_LATENCY (4)
    ) dut (
        .Clk      (Clk),
        .i_arst_n (arst_n),
        .i_ireq   (ireq),
        .o_iready (iready),
        .o_irsp   (irsp),
        .i_dreq   (dreq),
        .o_dready (dready),
        .o_drsp   (drsp)
    );

    always #50 Clk = ~Clk;

    function automatic logic lfsr_step();
        logic out;
        out  = lfsr[0];
        lfsr = lfsr >> 1;
        if (out) begin
            lfsr = lfsr ^ 16'hB400;   // taps 16 14 13 11
        end
        return out;
    endfunction

    function automatic logic [15:0] random_bits(input int n);
        logic [15:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[14:0], lfsr_step()};
        end
        return r;
    endfunction

    function automatic logic [15:0] expected_word(input logic [15:0] addr);
        if (written.exists(int'(addr))) begin
            return written[int'(addr)];
        end
        return addr ^ 16'hA5A5;   // content after reset
    endfunction

    // direct-mapped lookup, every access leaves its line resident
    function automatic logic predict_hit(input logic port, input addr_t a);
        logic hit;
        hit = shadow_valid[port][a.idx] && (shadow_tag[port][a.idx] == a.tag);
        shadow_valid[port][a.idx] = 1'b1;
        shadow_tag[port][a.idx]   = a.tag;
        return hit;
    endfunction

    task automatic report_counts();
        $display("checks %0d, data errors %0d, latency errors %0d, other errors %0d",
                 n_checks, data_errors, latency_errors, other_errors);
    endtask

    task automatic load_stimulus();
        int          fd;
        int          code;
        int          f_port;
        int          f_op;
        logic [15:0] f_addr;
        logic [15:0] f_wdata;
        logic [15:0] f_exp;
        string       line;
        fd = $fopen("cache_subsys_stim.txt", "r");
        if (fd == 0) begin
            $display("could not open the stimulus file cache_subsys_stim.txt");
            other_errors++;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                code = $fgets(line, fd);
                if (code > 0 && line.len() > 1 && line.getc(0) != 8'h23) begin
                    code = $sscanf(line, "%h %h %h %h %h", f_port, f_op, f_addr, f_wdata, f_exp);
                    if (code == 5) begin
                        stim_q.push_back('{port: f_port[0], op: f_op[1:0], addr: f_addr,
                                           wdata: f_wdata, exp_data: f_exp});
                    end else begin
                        $display("stimulus line could not be parsed: %s", line);
                        other_errors++;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic run_access(input logic port, input logic wr, input logic [15:0] addr,
                              input logic [15:0] wdata, input logic use_file,
                              input logic [15:0] file_exp);
        addr_t       a;
        logic        hit_pred;
        logic [15:0] exp_data;
        logic [15:0] rdata;
        int          cycles;
        string       name;
        a    = addr;
        name = port ? "dcache" : "icache";
        while (!(port ? dready : iready)) begin
            @(posedge Clk);
            #5;
        end
        hit_pred = predict_hit(port, a);
        exp_data = wr ? wdata : expected_word(addr);   // writes echo the stored word
        if (wr) begin
            written[int'(addr)] = wdata;
        end
        if (port) begin
            dreq = '{valid: 1'b1, write: wr, addr: a, wdata: wdata};
        end else begin
            ireq = '{valid: 1'b1, write: 1'b0, addr: a, wdata: '0};
        end
        @(posedge Clk);
        #5;
        if (port) begin
            dreq.valid = 1'b0;
        end else begin
            ireq.valid = 1'b0;
        end
        cycles = 1;
        while (!(port ? drsp.valid : irsp.valid)) begin
            @(posedge Clk);
            #5;
            cycles++;
        end
        rdata = port ? drsp.rdata : irsp.rdata;
        n_checks++;
        assert (rdata == exp_data) else begin
            data_errors++;
            $display("Mismatch at %0t: %s %s 0x%h returned 0x%h, model expects 0x%h",
                     $time, name, wr ? "write" : "read", addr, rdata, exp_data);
        end
        if (use_file) begin
            n_checks++;
            assert (rdata == file_exp) else begin
                data_errors++;
                $display("Mismatch at %0t: %s access 0x%h returned 0x%h, file expects 0x%h",
                         $time, name, addr, rdata, file_exp);
            end
        end
        n_checks++;
        assert (hit_pred == (cycles == 1)) else begin
            latency_errors++;
            $display("Mismatch at %0t: %s access 0x%h answered after %0d cycles as a %s",
                     $time, name, addr, cycles, hit_pred ? "hit" : "miss");
        end
        if (hit_pred) begin
            n_checks++;
            assert (port ? dready : iready) else begin
                other_errors++;
                $display("Mismatch at %0t: %s not ready in the cycle of its hit response",
                         $time, name);
            end
        end
    endtask

    initial begin
        stim_t       cur;
        stim_t       nxt;
        int          idx;
        logic [1:0]  mode;
        logic [15:0] iaddr;
        logic [15:0] daddr;
        logic        dwr;
        logic [15:0] wdata;
        logic [15:0] rbits;

        Clk            = 1'b0;
        arst_n         = 1'b0;
        ireq           = '0;
        dreq           = '0;
        lfsr           = 16'd58808;
        stim_loaded    = 1'b0;
        n_checks       = 0;
        data_errors    = 0;
        latency_errors = 0;
        other_errors   = 0;
        foreach (shadow_valid[p, l]) begin
            shadow_valid[p][l] = 1'b0;
        end
        load_stimulus();
        stim_loaded = 1'b1;

        repeat (4) @(posedge Clk);
        #5;
        arst_n = 1'b1;
        @(posedge Clk);
        #5;
        n_checks++;
        assert (iready && dready && !irsp.valid && !drsp.valid) else begin
            other_errors++;
            $display("Mismatch at %0t: ready %b/%b rsp valid %b/%b after reset",
                     $time, iready, dready, irsp.valid, drsp.valid);
        end

        idx = 0;
        while (idx < stim_q.size()) begin
            cur = stim_q[idx];
            if (cur.op == OP_PAIR && idx + 1 < stim_q.size()) begin
                nxt = stim_q[idx + 1];
                fork
                    run_access(cur.port, 1'b0, cur.addr, cur.wdata, 1'b1, cur.exp_data);
                    run_access(nxt.port, nxt.op == OP_WRITE, nxt.addr, nxt.wdata, 1'b1,
                               nxt.exp_data);
                join
                idx += 2;
            end else begin
                run_access(cur.port, cur.op == OP_WRITE, cur.addr, cur.wdata, 1'b1,
                           cur.exp_data);
                idx++;
            end
        end

        for (int n = 0; n < RAND_OPS; n++) begin
            rbits = random_bits(2);
            mode  = rbits[1:0];
            rbits = random_bits(7);
            iaddr = {9'h000, rbits[6:0]};   // code region
            rbits = random_bits(7);
            daddr = {9'h100, rbits[6:0]};   // data region
            rbits = random_bits(1);
            dwr   = rbits[0];
            wdata = random_bits(16);
            case (mode)
                2'd0: run_access(1'b0, 1'b0, iaddr, '0, 1'b0, '0);
                2'd1: run_access(1'b1, dwr, daddr, wdata, 1'b0, '0);
                default: begin
                    fork
                        run_access(1'b0, 1'b0, iaddr, '0, 1'b0, '0);
                        run_access(1'b1, dwr, daddr, wdata, 1'b0, '0);
                    join
                end
            endcase
        end

        report_counts();
        if (data_errors == 0 && latency_errors == 0 && other_errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    initial begin
        wait (stim_loaded);
        repeat ((stim_q.size() + RAND_OPS) * CYC_PER_OP) @(posedge Clk);
        $display("timeout: the tests did not finish in the allowed number of cycles");
        report_counts();
        $display("CHECKS FAILED");
        $finish;
    end

endmodule

// File: cache_subsys_top.f
cache_pkg.sv
line_memory.sv
mem_arbiter.sv
icache.sv
dcache.sv
cache_subsys_top.sv
cache_subsys_tb.sv

// File: cache_subsys_top.sv
`timescale 1ns/1ps

module cache_subsys_top import cache_pkg::*; #(
    parameter int MEM_QDEPTH  = 2,
    parameter int MEM_LATENCY = 4
) (
    input  logic     Clk,
    input  logic     i_arst_n,
    input  cpu_req_t i_ireq,
    output logic     o_iready,
    output cpu_rsp_t o_irsp,
    input  cpu_req_t i_dreq,
    output logic     o_dready,
    output cpu_rsp_t o_drsp
);

    mem_req_t icache_mem_req;
    mem_req_t dcache_mem_req;
    mem_req_t mem_req;
    logic     igrant;
    logic     dgrant;
    logic     credit;
    mem_rsp_t mem_rsp;
    mem_rsp_t icache_mem_rsp;
    mem_rsp_t dcache_mem_rsp;

    icache u_icache (
        .Clk         (Clk),
        .i_arst_n    (i_arst_n),
        .i_req       (i_ireq),
        .o_ready     (o_iready),
        .o_rsp       (o_irsp),
        .o_mem_req   (icache_mem_req),
        .i_mem_grant (igrant),
        .i_mem_rsp   (icache_mem_rsp)
    );

    dcache u_dcache (
        .Clk         (Clk),
        .i_arst_n    (i_arst_n),
        .i_req       (i_dreq),
        .o_ready     (o_dready),
        .o_rsp       (o_drsp),
        .o_mem_req   (dcache_mem_req),
        .i_mem_grant (dgrant),
        .i_mem_rsp   (dcache_mem_rsp)
    );

    mem_arbiter #(
        .MEM_QDEPTH (MEM_QDEPTH)
    ) u_arbiter (
        .Clk       (Clk),
        .i_arst_n  (i_arst_n),
        .i_ireq    (icache_mem_req),
        .i_dreq    (dcache_mem_req),
        .o_igrant  (igrant),
        .o_dgrant  (dgrant),
        .o_mem_req (mem_req),
        .i_credit  (credit),
        .i_mem_rsp (mem_rsp),
        .o_irsp    (icache_mem_rsp),
        .o_drsp    (dcache_mem_rsp)
    );

    line_memory #(
        .MEM_QDEPTH  (MEM_QDEPTH),
        .MEM_LATENCY (MEM_LATENCY)
    ) u_memory (
        .Clk      (Clk),
        .i_arst_n (i_arst_n),
        .i_req    (mem_req),
        .o_credit (credit),
        .o_rsp    (mem_rsp)
    );

endmodule

// File: dcache.sv
`timescale 1ns/1ps

module dcache import cache_pkg::*; (
    input  logic     Clk,
    input  logic     i_arst_n,
    input  cpu_req_t i_req,
    output logic     o_ready,
    output cpu_rsp_t o_rsp,
    output mem_req_t o_mem_req,
    input  logic     i_mem_grant,
    input  mem_rsp_t i_mem_rsp
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_WB,
        ST_RD,
        ST_WAIT
    } state_e;

    state_e           state;
    logic [TAG_W-1:0] tag_arr [LINES];
    logic [LINES-1:0] valid_arr;
    logic [LINES-1:0] dirty_arr;
    mem_line_u        data_arr [LINES];
    cpu_req_t         req_q;
    logic             accept;
    logic             hit;
    logic             victim_dirty;
    logic             fill;
    mem_line_u        fill_line;
    logic             rsp_valid;
    word_t            rsp_data;

    assign o_ready      = (state == ST_IDLE);
    assign accept       = i_req.valid && o_ready;
    assign hit          = valid_arr[i_req.addr.idx] && (tag_arr[i_req.addr.idx] == i_req.addr.tag);
    assign victim_dirty = valid_arr[i_req.addr.idx] && dirty_arr[i_req.addr.idx];
    assign fill         = (state == ST_WAIT) && i_mem_rsp.valid;
    assign o_rsp        = '{valid: rsp_valid, rdata: rsp_data};

    // write-allocate merges the store word into the fetched line
    always_comb begin
        fill_line = i_mem_rsp.rdata;
        if (req_q.write) begin
            fill_line.words[req_q.addr.ofs] = req_q.wdata;
        end
    end

    always_comb begin
        o_mem_req     = '0;
        o_mem_req.src = DCACHE;
        case (state)
            ST_WB: begin
                o_mem_req.valid     = 1'b1;
                o_mem_req.write     = 1'b1;
                o_mem_req.line_addr = {tag_arr[req_q.addr.idx], req_q.addr.idx};   // victim
                o_mem_req.wdata     = data_arr[req_q.addr.idx];
            end
            ST_RD: begin
                o_mem_req.valid     = 1'b1;
                o_mem_req.line_addr = {req_q.addr.tag, req_q.addr.idx};
            end
            default: o_mem_req.valid = 1'b0;
        endcase
    end

    always_ff @(posedge Clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            state     <= ST_IDLE;
            valid_arr <= '0;
            dirty_arr <= '0;
            rsp_valid <= 1'b0;
        end else begin
            rsp_valid <= (accept && hit) || fill;
            case (state)
                ST_IDLE: begin
                    if (accept && hit && i_req.write) begin
                        dirty_arr[i_req.addr.idx] <= 1'b1;
                    end
                    if (accept && !hit) begin
                        state <= victim_dirty ? ST_WB : ST_RD;
                    end
                end
                ST_WB: begin
                    if (i_mem_grant) begin
                        state <= ST_RD;   // read queues behind the writeback
                    end
                end
                ST_RD: begin
                    if (i_mem_grant) begin
                        state <= ST_WAIT;
                    end
                end
                ST_WAIT: begin
                    if (fill) begin
                        valid_arr[req_q.addr.idx] <= 1'b1;
                        dirty_arr[req_q.addr.idx] <= req_q.write;
                        state                     <= ST_IDLE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge Clk) begin
        if (accept) begin
            req_q <= i_req;
        end
        if (accept && hit) begin
            if (i_req.write) begin
                data_arr[i_req.addr.idx].words[i_req.addr.ofs] <= i_req.wdata;
                rsp_data                                       <= i_req.wdata;   // echo
            end else begin
                rsp_data <= data_arr[i_req.addr.idx].words[i_req.addr.ofs];
            end
        end
        if (fill) begin
            tag_arr[req_q.addr.idx]  <= req_q.addr.tag;
            data_arr[req_q.addr.idx] <= fill_line;
            rsp_data                 <= fill_line.words[req_q.addr.ofs];
        end
    end

endmodule

// File: icache.sv
`timescale 1ns/1ps

module icache import cache_pkg::*; (
    input  logic     Clk,
    input  logic     i_arst_n,
    input  cpu_req_t i_req,
    output logic     o_ready,
    output cpu_rsp_t o_rsp,
    output mem_req_t o_mem_req,
    input  logic     i_mem_grant,
    input  mem_rsp_t i_mem_rsp
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_REQ,
        ST_WAIT
    } state_e;

    state_e           state;
    logic [TAG_W-1:0] tag_arr [LINES];
    logic [LINES-1:0] valid_arr;
    mem_line_u        data_arr [LINES];
    addr_t            req_addr;
    logic             accept;
    logic             hit;
    logic             fill;
    logic             rsp_valid;
    word_t            rsp_data;

    assign o_ready = (state == ST_IDLE);
    assign accept  = i_req.valid && o_ready;
    assign hit     = valid_arr[i_req.addr.idx] && (tag_arr[i_req.addr.idx] == i_req.addr.tag);
    assign fill    = (state == ST_WAIT) && i_mem_rsp.valid;
    assign o_rsp   = '{valid: rsp_valid, rdata: rsp_data};

    always_comb begin
        o_mem_req           = '0;
        o_mem_req.valid     = (state == ST_REQ);   // held until granted
        o_mem_req.src       = ICACHE;
        o_mem_req.line_addr = {req_addr.tag, req_addr.idx};
    end

    always_ff @(posedge Clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            state     <= ST_IDLE;
            valid_arr <= '0;
            rsp_valid <= 1'b0;
        end else begin
            rsp_valid <= (accept && hit) || fill;
            case (state)
                ST_IDLE: begin
                    if (accept && !hit) begin
                        state <= ST_REQ;
                    end
                end
                ST_REQ: begin
                    if (i_mem_grant) begin
                        state <= ST_WAIT;
                    end
                end
                ST_WAIT: begin
                    if (fill) begin
                        valid_arr[req_addr.idx] <= 1'b1;
                        state                   <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge Clk) begin
        if (accept) begin
            req_addr <= i_req.addr;
        end
        if (accept && hit) begin
            rsp_data <= data_arr[i_req.addr.idx].words[i_req.addr.ofs];
        end
        if (fill) begin
            tag_arr[req_addr.idx]  <= req_addr.tag;
            data_arr[req_addr.idx] <= i_mem_rsp.rdata;
            rsp_data               <= i_mem_rsp.rdata.words[req_addr.ofs];   // critical word
        end
    end

endmodule

// File: line_memory.sv
`timescale 1ns/1ps

module line_memory import cache_pkg::*; #(
    parameter int MEM_QDEPTH  = 2,
    parameter int MEM_LATENCY = 4
) (
    input  logic     Clk,
    input  logic     i_arst_n,
    input  mem_req_t i_req,
    output logic     o_credit,
    output mem_rsp_t o_rsp
);

    localparam int PTR_W = (MEM_QDEPTH > 1) ? $clog2(MEM_QDEPTH) : 1;
    localparam int CNT_W = $clog2(MEM_QDEPTH + 1);
    localparam int LAT_W = (MEM_LATENCY > 1) ? $clog2(MEM_LATENCY) : 1;

    mem_line_u        store [2**LADDR_W];
    mem_req_t         queue [MEM_QDEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] q_count;
    mem_req_t         cur;
    logic             busy;
    logic [LAT_W-1:0] lat_cnt;
    logic             push;
    logic             pop;
    logic             done;
    logic             rsp_valid;
    src_t             rsp_src;
    mem_line_u        rsp_data;

    function automatic mem_line_u init_line(input line_addr_t la);
        mem_line_u l;
        for (int w = 0; w < LINE_WORDS; w++) begin
            l.words[w] = init_word(addr_t'({la, OFS_W'(w)}));
        end
        return l;
    endfunction

    assign push     = i_req.valid;   // arbiter only sends with a credit
    assign done     = busy && (lat_cnt == '0);
    assign pop      = (q_count != '0) && (!busy || done);
    assign o_credit = pop;
    assign o_rsp    = '{valid: rsp_valid, src: rsp_src, rdata: rsp_data};

    always_ff @(posedge Clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            q_count   <= '0;
            busy      <= 1'b0;
            lat_cnt   <= '0;
            rsp_valid <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(MEM_QDEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(MEM_QDEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   q_count <= q_count + 1'b1;
                2'b01:   q_count <= q_count - 1'b1;
                default: q_count <= q_count;
            endcase
            if (pop) begin
                busy    <= 1'b1;
                lat_cnt <= LAT_W'(MEM_LATENCY - 1);
            end else if (done) begin
                busy <= 1'b0;
            end else if (busy) begin
                lat_cnt <= lat_cnt - 1'b1;
            end
            rsp_valid <= done && !cur.write;   // writes are silent
        end
    end

    always_ff @(posedge Clk) begin
        if (push) begin
            queue[wr_ptr] <= i_req;
        end
        if (pop) begin
            cur <= queue[rd_ptr];
        end
        if (done) begin
            rsp_src  <= cur.src;
            rsp_data <= store[cur.line_addr];
        end
    end

    // storage comes up with the known pattern at every reset
    always_ff @(posedge Clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            for (int i = 0; i < 2**LADDR_W; i++) begin
                store[i] <= init_line(line_addr_t'(i));
            end
        end else if (done && cur.write) begin
            store[cur.line_addr] <= cur.wdata;
        end
    end

endmodule

// File: mem_arbiter.sv
`timescale 1ns/1ps

module mem_arbiter import cache_pkg::*; #(
    parameter int MEM_QDEPTH = 2
) (
    input  logic     Clk,
    input  logic     i_arst_n,
    input  mem_req_t i_ireq,
    input  mem_req_t i_dreq,
    output logic     o_igrant,
    output logic     o_dgrant,
    output mem_req_t o_mem_req,
    input  logic     i_credit,
    input  mem_rsp_t i_mem_rsp,
    output mem_rsp_t o_irsp,
    output mem_rsp_t o_drsp
);

    localparam int CNT_W = $clog2(MEM_QDEPTH + 1);

    logic [CNT_W-1:0] credits;
    src_t             prio;
    logic             have_credit;
    logic             granted;

    assign have_credit = (credits != '0);
    assign o_igrant    = have_credit && i_ireq.valid && (prio == ICACHE || !i_dreq.valid);
    assign o_dgrant    = have_credit && i_dreq.valid && (prio == DCACHE || !i_ireq.valid);
    assign granted     = o_igrant || o_dgrant;

    always_comb begin
        o_mem_req = '0;
        if (o_igrant) begin
            o_mem_req = i_ireq;
        end else if (o_dgrant) begin
            o_mem_req = i_dreq;
        end
    end

    // responses go back to whoever asked
    always_comb begin
        o_irsp       = i_mem_rsp;
        o_irsp.valid = i_mem_rsp.valid && (i_mem_rsp.src == ICACHE);
        o_drsp       = i_mem_rsp;
        o_drsp.valid = i_mem_rsp.valid && (i_mem_rsp.src == DCACHE);
    end

    always_ff @(posedge Clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            credits <= CNT_W'(MEM_QDEPTH);
            prio    <= ICACHE;
        end else begin
            case ({granted, i_credit})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;   // none or both
            endcase
            if (o_igrant) begin
                prio <= DCACHE;
            end else if (o_dgrant) begin
                prio <= ICACHE;
            end
        end
    end

endmodule

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal --top-module cache_subsys_tb \
    -f cache_subsys_top.f --Mdir obj_dir -o cache_subsys_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

sim_out=$(./obj_dir/cache_subsys_sim)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -qx "ALL CHECKS PASSED"; then
    exit 0
fi
echo "pass message not found"
exit 1
